// ==== hw/udma_reg_pkg.sv ====
// Register-map types of the micro DMA engine, shared by the CPU register decode,
// the channels and the mover.
package udma_reg_pkg;

    typedef logic [5:0]  reg_addr_t; // cpu register address, group in 5:4 and channel in 3:2.
    typedef logic [15:0] count_t;    // remaining transfers of a channel.
    typedef logic [7:0]  mode_t;     // size in 1:0, addressing in 4:2, upper bits unused.

    // which register of a channel a configuration write targets.
    typedef enum logic [1:0] {
        FLD_SRC  = 2'd0,  // source address.
        FLD_DST  = 2'd1,  // destination address.
        FLD_CNT  = 2'd2,  // count, with the mode riding in bits 23:16.
        FLD_MODE = 2'd3   // mode alone in bits 7:0.
    } field_t;

    localparam int MODE_SIZE_LSB = 0; // item size field.
    localparam int MODE_SIZE_MSB = 1;
    localparam int MODE_AM_LSB   = 2; // addressing field.
    localparam int MODE_AM_MSB   = 4;

    localparam logic [1:0] SIZE_ILLEGAL = 2'd3; // no item size has this code.

    localparam logic [2:0] AM_DST_UP = 3'd0; // destination counts up.
    localparam logic [2:0] AM_DST_DN = 3'd1; // destination counts down.
    localparam logic [2:0] AM_SRC_UP = 3'd2; // source counts up.
    localparam logic [2:0] AM_SRC_DN = 3'd3; // source counts down.
    localparam logic [2:0] AM_FIXED  = 3'd4; // codes above this one are illegal.

endpackage

// ==== hw/udma_bus_pkg.sv ====
// Memory-side types of the micro DMA engine: address, data and item size,
// with the helpers that turn an item size into a data mask or an address step.
package udma_bus_pkg;

    typedef logic [31:0] addr_t; // byte address on the memory port.
    typedef logic [31:0] data_t; // data word, items sit in the low lanes.

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_WORD = 2'd1,
        SZ_LONG = 2'd2
    } xfer_size_t;

    // keeps only the lanes that belong to an item of the given size.
    function automatic data_t size_mask(xfer_size_t sz);
        case (sz)
            SZ_BYTE: return 32'h0000_00ff;
            SZ_WORD: return 32'h0000_ffff;
            default: return '1;
        endcase
    endfunction

    // address increment for one item, zero for the illegal code.
    function automatic addr_t size_step(xfer_size_t sz);
        case (sz)
            SZ_BYTE: return 32'd1;
            SZ_WORD: return 32'd2;
            SZ_LONG: return 32'd4;
            default: return '0;
        endcase
    endfunction

endpackage

// ==== hw/udma_chan_if.sv ====
// One channel's link between the CPU register decode, the channel itself and
// the memory mover. The top level makes one instance per channel.
`timescale 1ns/100ps

interface udma_chan_if;
    import udma_reg_pkg::*;
    import udma_bus_pkg::*;

    logic   cfg_we;    // one-cycle write strobe from the register decode.
    field_t cfg_field; // register that the strobe targets.
    data_t  cfg_wdata; // full new value, lanes already merged.
    addr_t  src;       // current source address.
    addr_t  dst;       // current destination address.
    count_t cnt;       // transfers still to go.
    mode_t  mode;      // item size and addressing.
    logic   pend;      // a legal trigger waits for service.
    logic   grant;     // the mover is working for this channel.
    logic   fin;       // one-cycle pulse at the end of the write phase.

    modport regs (
        output cfg_we, cfg_field, cfg_wdata,
        input  src, dst, cnt, mode
    );

    modport chan (
        input  cfg_we, cfg_field, cfg_wdata, grant, fin,
        output src, dst, cnt, mode, pend
    );

    modport mover (
        input  pend, src, dst, mode,
        output grant, fin
    );

endinterface

// ==== hw/udma_regs.sv ====
// CPU side of the micro DMA engine: decodes the register map, merges lane writes
// into the channel registers and returns a registered readback.
`timescale 1ns/100ps

module udma_regs #(
    parameter int NUM_CH = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  udma_bus_pkg::data_t     din,
    output udma_bus_pkg::data_t     dout,
    input  udma_reg_pkg::reg_addr_t addr,
    input  logic                    qs,
    input  logic                    ws,
    input  logic                    bs,
    input  logic                    we,
    input  logic                    nstinc,
    input  logic                    nstdec,
    udma_chan_if.regs               ch [NUM_CH]
);
    import udma_reg_pkg::*;
    import udma_bus_pkg::*;

    logic [1:0]  grp;          // register group from addr[5:4].
    logic [1:0]  sel;          // channel from addr[3:2].
    logic        sel_ok;       // the addressed channel exists.
    logic        wr;           // a lane write to a channel register this cycle.
    addr_t       src_a  [NUM_CH];
    addr_t       dst_a  [NUM_CH];
    count_t      cnt_a  [NUM_CH];
    mode_t       mode_a [NUM_CH];
    addr_t       cur_src;
    addr_t       cur_dst;
    count_t      cur_cnt;
    mode_t       cur_mode;
    count_t      cnt_merge;    // count with one byte lane replaced.
    field_t      field;
    data_t       wdata;
    logic [15:0] nest;         // interrupt nesting level.

    assign grp    = addr[5:4];
    assign sel    = addr[3:2];
    assign sel_ok = {1'b0, sel} < 3'(NUM_CH);  // channels above NUM_CH read as zero.
    assign wr     = cen & we & (qs | ws | bs) & (grp != 2'd3) & sel_ok;

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        assign src_a[i]        = ch[i].src;   // gather so that a channel can be picked by index.
        assign dst_a[i]        = ch[i].dst;
        assign cnt_a[i]        = ch[i].cnt;
        assign mode_a[i]       = ch[i].mode;
        assign ch[i].cfg_we    = wr && (sel == 2'(i)); // only the addressed channel sees the strobe.
        assign ch[i].cfg_field = field;
        assign ch[i].cfg_wdata = wdata;
    end

    always_comb begin
        cur_src  = '0;
        cur_dst  = '0;
        cur_cnt  = '0;
        cur_mode = '0;
        if (sel_ok) begin
            cur_src  = src_a[sel];
            cur_dst  = dst_a[sel];
            cur_cnt  = cnt_a[sel];
            cur_mode = mode_a[sel];
        end
    end

    // lanes not strobed keep the value that the channel holds now.
    always_comb begin
        field     = grp[0] ? FLD_DST : FLD_SRC;
        wdata     = grp[0] ? cur_dst : cur_src;
        cnt_merge = cur_cnt;
        cnt_merge[{addr[0], 3'd0} +: 8] = din[7:0]; // byte lane of the count.
        if (grp[1]) begin
            if (qs) begin
                field = FLD_CNT;                    // mode lands over the count.
                wdata = {8'd0, din[23:0]};
            end else if (addr[1]) begin
                field = FLD_MODE;                   // word and byte both reach the mode alone.
                wdata = {24'd0, din[7:0]};
            end else begin
                field = FLD_CNT;
                wdata = {8'd0, cur_mode, ws ? din[15:0] : cnt_merge};
            end
        end else if (qs) begin
            wdata = din;
        end else if (ws) begin
            wdata[{addr[1], 4'd0} +: 16] = din[15:0];
        end else begin
            wdata[{addr[1:0], 3'd0} +: 8] = din[7:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout <= '0;
        end else if (cen) begin
            case (grp)
                2'd0: dout <= cur_src;
                2'd1: dout <= cur_dst;
                2'd2: dout <= addr[1] ? {24'd0, cur_mode} : {8'd0, cur_mode, cur_cnt};
                default: dout <= {16'd0, nest};
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            nest <= '0;
        end else if (cen) begin
            nest <= nest + 16'(nstinc) - 16'(nstdec); // both at once leave it unchanged.
        end
    end

    // the lane strobes come from the CPU and must not overlap.
    a_one_lane: assert property (@(posedge clk) disable iff (rst)
        (cen && we) |-> $onehot0({qs, ws, bs}));

endmodule

// ==== hw/udma_channel.sv ====
// One DMA channel: holds its address, count and mode registers, latches triggers
// and steps its state after each transfer that the mover completes.
`timescale 1ns/100ps

module udma_channel (
    input  logic      clk,
    input  logic      rst,
    input  logic      trig,
    output logic      done,
    udma_chan_if.chan bus
);
    import udma_reg_pkg::*;
    import udma_bus_pkg::*;

    addr_t      src;
    addr_t      dst;
    count_t     cnt;
    mode_t      mode;
    logic       pend;
    logic       last;      // the transfer just finished emptied the count.
    logic [1:0] size_code;
    logic [2:0] am;        // addressing code.
    logic       legal;
    addr_t      step;
    count_t     cnt_after; // count as it will be after this edge.
    logic       trig_ok;

    assign bus.src  = src;
    assign bus.dst  = dst;
    assign bus.cnt  = cnt;
    assign bus.mode = mode;
    assign bus.pend = pend;

    assign size_code = mode[MODE_SIZE_MSB:MODE_SIZE_LSB];
    assign am        = mode[MODE_AM_MSB:MODE_AM_LSB];
    assign legal     = (size_code != SIZE_ILLEGAL) && (am <= AM_FIXED);
    assign step      = size_step(xfer_size_t'(size_code)); // 1, 2 or 4 bytes.
    assign cnt_after = (bus.fin && cnt != '0) ? cnt - 16'd1 : cnt;
    assign trig_ok   = trig && legal && (cnt_after != '0); // other triggers are dropped.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            src  <= '0;
            dst  <= '0;
            cnt  <= '0;
            mode <= '0;
            pend <= 1'b0;
            last <= 1'b0;
            done <= 1'b0;
        end else begin
            pend <= trig_ok || (pend && !bus.fin); // a repeated trigger merges into pend.
            last <= bus.fin && (cnt == 16'd1);
            done <= last;                          // one cycle after the count hits zero.
            if (bus.cfg_we) begin
                case (bus.cfg_field)
                    FLD_SRC: src <= bus.cfg_wdata;
                    FLD_DST: dst <= bus.cfg_wdata;
                    FLD_CNT: begin
                        cnt  <= bus.cfg_wdata[15:0];
                        mode <= bus.cfg_wdata[23:16]; // quad writes set both at once.
                    end
                    default: mode <= bus.cfg_wdata[7:0];
                endcase
            end
            if (bus.fin) begin
                cnt <= cnt_after; // the end of a transfer overrides a write in the same cycle.
                case (am)
                    AM_DST_UP: dst <= dst + step;
                    AM_DST_DN: dst <= dst - step;
                    AM_SRC_UP: src <= src + step;
                    AM_SRC_DN: src <= src - step;
                    default: ;    // fixed addressing moves nothing.
                endcase
            end
        end
    end

    // the mover may only finish a transfer that it granted to a pending channel.
    a_fin_pend: assert property (@(posedge clk) disable iff (rst)
        bus.fin |-> (pend && bus.grant));

endmodule

// ==== hw/udma_mover.sv ====
// Memory sequencer of the micro DMA engine: grants the lowest pending channel and
// moves one item with a read then a write, both on a four-phase req/ack handshake.
`timescale 1ns/100ps

module udma_mover #(
    parameter int NUM_CH = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    udma_chan_if.mover               ch [NUM_CH],
    output logic                     mem_req,
    output logic                     mem_we,
    output udma_bus_pkg::addr_t      mem_addr,
    output udma_bus_pkg::xfer_size_t mem_size,
    output udma_bus_pkg::data_t      mem_wdata,
    input  logic                     mem_ack,
    input  udma_bus_pkg::data_t      mem_rdata
);
    import udma_reg_pkg::*;
    import udma_bus_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_REQ,
        S_RD_REL,
        S_WR_REQ,
        S_WR_REL,
        S_FIN
    } state_t;

    state_t            state;
    logic [NUM_CH-1:0] pend_v;
    addr_t             src_a  [NUM_CH];
    addr_t             dst_a  [NUM_CH];
    mode_t             mode_a [NUM_CH];
    logic [NUM_CH-1:0] grant_q;
    logic [1:0]        gsel;    // index of the granted channel.
    logic [1:0]        pick;    // lowest pending channel.
    logic              any;
    logic              start;

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        assign pend_v[i]   = ch[i].pend;
        assign src_a[i]    = ch[i].src;
        assign dst_a[i]    = ch[i].dst;
        assign mode_a[i]   = ch[i].mode;
        assign ch[i].grant = grant_q[i];
        assign ch[i].fin   = grant_q[i] && (state == S_FIN);
    end

    // fixed priority, the loop runs downwards so that channel 0 wins.
    always_comb begin
        any  = 1'b0;
        pick = '0;
        for (int i = NUM_CH - 1; i >= 0; i--) begin
            if (pend_v[i]) begin
                any  = 1'b1;
                pick = 2'(i);
            end
        end
    end

    assign start = (state == S_IDLE) && any;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            grant_q <= '0;
            gsel    <= '0;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (any) begin
                    gsel    <= pick;
                    grant_q <= NUM_CH'(1) << pick;
                    mem_req <= 1'b1; // read request goes out with the source address.
                    mem_we  <= 1'b0;
                    state   <= S_RD_REQ;
                end
                S_RD_REQ: if (mem_ack) begin
                    mem_req <= 1'b0;
                    state   <= S_RD_REL;
                end
                S_RD_REL: if (!mem_ack) begin
                    mem_req <= 1'b1; // ack is low again, the write may start.
                    mem_we  <= 1'b1;
                    state   <= S_WR_REQ;
                end
                S_WR_REQ: if (mem_ack) begin
                    mem_req <= 1'b0;
                    state   <= S_WR_REL;
                end
                S_WR_REL: if (!mem_ack) begin
                    state <= S_FIN;
                end
                S_FIN: begin
                    grant_q <= '0; // fin reaches the channel during this cycle.
                    mem_we  <= 1'b0;
                    state   <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mem_addr <= src_a[pick];
            mem_size <= xfer_size_t'(mode_a[pick][MODE_SIZE_MSB:MODE_SIZE_LSB]);
        end
        if (state == S_RD_REQ && mem_ack) begin
            mem_wdata <= mem_rdata & size_mask(mem_size); // read data is valid while ack is high.
        end
        if (state == S_RD_REL && !mem_ack) begin
            mem_addr <= dst_a[gsel];
        end
    end

    // the grant sits on one pending channel for a whole transfer and is clear when idle.
    a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
        (state == S_IDLE) ? (grant_q == '0)
                          : ($onehot(grant_q) && ((grant_q & ~pend_v) == '0)));

    // a request and its address are held until the responder has seen it.
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        (mem_req && !mem_ack) |=> (mem_req && $stable(mem_addr)));

endmodule

// ==== hw/udma_top.sv ====
// Top level of the micro DMA engine: CPU register port, per-channel triggers and
// done pulses, and the four-phase memory port, all as plain ports.
`timescale 1ns/100ps

module udma_top #(
    parameter int NUM_CH = 4 // 1 to 4, the register map decodes two channel bits.
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cen,
    input  udma_bus_pkg::data_t      din,
    output udma_bus_pkg::data_t      dout,
    input  udma_reg_pkg::reg_addr_t  addr,
    input  logic                     qs,
    input  logic                     ws,
    input  logic                     bs,
    input  logic                     we,
    input  logic                     nstinc,
    input  logic                     nstdec,
    input  logic [NUM_CH-1:0]        dma_trig,
    output logic [NUM_CH-1:0]        dma_done,
    output logic                     mem_req,
    output logic                     mem_we,
    output udma_bus_pkg::addr_t      mem_addr,
    output udma_bus_pkg::xfer_size_t mem_size,
    output udma_bus_pkg::data_t      mem_wdata,
    input  logic                     mem_ack,
    input  udma_bus_pkg::data_t      mem_rdata
);

    udma_chan_if u_chan_if [NUM_CH] (); // one link per channel.

    udma_regs #(
        .NUM_CH (NUM_CH)
    ) u_regs (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .din    (din),
        .dout   (dout),
        .addr   (addr),
        .qs     (qs),
        .ws     (ws),
        .bs     (bs),
        .we     (we),
        .nstinc (nstinc),
        .nstdec (nstdec),
        .ch     (u_chan_if)
    );

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        udma_channel u_channel (
            .clk  (clk),
            .rst  (rst),
            .trig (dma_trig[i]),
            .done (dma_done[i]),
            .bus  (u_chan_if[i])
        );
    end

    udma_mover #(
        .NUM_CH (NUM_CH)
    ) u_mover (
        .clk       (clk),
        .rst       (rst),
        .ch        (u_chan_if),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_size  (mem_size),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== dv/tb_clk.sv ====
// Clock and reset source for the DMA testbench: 40 ns clock, reset held for two cycles.
`timescale 1ns/100ps

module tb_clk #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;                        // reset is active from time zero.
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;                       // released on a rising edge, like the stimulus.
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== dv/udma_tb.sv ====
// Testbench of the micro DMA engine: drives the CPU port and triggers, answers the
// memory handshake and checks writes and readback against a model of the register map.
`timescale 1ns/100ps

module udma_tb;
    import udma_reg_pkg::*;
    import udma_bus_pkg::*;

    localparam int         NUM_CH     = 4;
    localparam int         WAIT_LIMIT = 400;            // cycles that any wait may take.
    localparam data_t      RD_PATTERN = 32'hA5A5_0000;  // read data is the address xor this.
    localparam logic [2:0] LN_QUAD    = 3'b100;         // lane strobes as {qs, ws, bs}.
    localparam logic [2:0] LN_WORD    = 3'b010;
    localparam logic [2:0] LN_BYTE    = 3'b001;

    logic              clk;
    logic              rst;
    logic              cen;
    data_t             din;
    data_t             dout;
    reg_addr_t         addr;
    logic              qs;
    logic              ws;
    logic              bs;
    logic              we;
    logic              nstinc;
    logic              nstdec;
    logic [NUM_CH-1:0] dma_trig;
    logic [NUM_CH-1:0] dma_done;
    logic              mem_req;
    logic              mem_we;
    addr_t             mem_addr;
    xfer_size_t        mem_size;
    data_t             mem_wdata;
    logic              mem_ack   = 1'b0;  // the responder owns these two.
    data_t             mem_rdata = '0;

    int    errors      = 0;
    int    checks      = 0;
    int    tests       = 0;
    int    err_mark    = 0;  // error count when the current test began.
    int    writes_seen = 0;
    int    ack_wait    = 0;  // cycles the responder still holds back its ack.
    int    done_cnt  [NUM_CH];
    int    done_base [NUM_CH];
    addr_t m_src     [NUM_CH];  // model of each channel's addresses and mode.
    addr_t m_dst     [NUM_CH];
    mode_t m_mode    [NUM_CH];
    data_t exp_addr_q [$];      // writes the model expects, in order.
    data_t exp_data_q [$];
    data_t exp_size_q [$];

    tb_clk u_clk (
        .clk (clk),
        .rst (rst)
    );

    udma_top #(
        .NUM_CH (NUM_CH)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .din       (din),
        .dout      (dout),
        .addr      (addr),
        .qs        (qs),
        .ws        (ws),
        .bs        (bs),
        .we        (we),
        .nstinc    (nstinc),
        .nstdec    (nstdec),
        .dma_trig  (dma_trig),
        .dma_done  (dma_done),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_size  (mem_size),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    function automatic reg_addr_t reg_addr_of(input int grp, input int chn, input int lane);
        return reg_addr_t'((grp << 4) | (chn << 2) | lane); // group, channel, lane.
    endfunction

    function automatic data_t item_mask(input int size_code);
        int bytes;
        bytes = 1 << size_code;                              // 1, 2 or 4 bytes.
        if (bytes == 4)
            return 32'hFFFF_FFFF;
        return (32'd1 << (8 * bytes)) - 32'd1;
    endfunction

    task automatic check_eq(input string name, input data_t got, input data_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic report_test(input int num, input string name);
        tests++;
        if (errors == err_mark)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: FAIL, %0d errors", num, name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic reg_write(input reg_addr_t a, input data_t d, input logic [2:0] qwb);
        @(posedge clk);
        cen          <= 1'b1;
        we           <= 1'b1;
        addr         <= a;
        din          <= d;
        {qs, ws, bs} <= qwb;
        @(posedge clk);                 // the register takes the value at this edge.
        cen          <= 1'b0;
        we           <= 1'b0;
        {qs, ws, bs} <= 3'b000;
    endtask

    task automatic reg_read(input reg_addr_t a, input data_t exp);
        @(posedge clk);
        cen  <= 1'b1;
        we   <= 1'b0;
        addr <= a;
        @(posedge clk);
        cen  <= 1'b0;
        @(negedge clk);                 // dout was registered at the edge before.
        check_eq($sformatf("dout at register %h", a), dout, exp);
    endtask

    task automatic nest_pulse(input logic inc, input logic dec);
        @(posedge clk);
        cen    <= 1'b1;
        we     <= 1'b0;
        addr   <= reg_addr_of(3, 0, 0);
        nstinc <= inc;
        nstdec <= dec;
        @(posedge clk);
        cen    <= 1'b0;
        nstinc <= 1'b0;
        nstdec <= 1'b0;
    endtask

    task automatic trigger(input logic [NUM_CH-1:0] which);
        @(posedge clk);
        dma_trig <= which;
        @(posedge clk);
        dma_trig <= '0;                 // a one-cycle pulse per channel.
    endtask

    // sets one channel up with quad writes and mirrors the values in the model.
    task automatic configure(input int c, input addr_t src, input addr_t dst,
                             input count_t cnt, input mode_t mode);
        reg_write(reg_addr_of(0, c, 0), src, LN_QUAD);
        reg_write(reg_addr_of(1, c, 0), dst, LN_QUAD);
        reg_write(reg_addr_of(2, c, 0), {8'd0, mode, cnt}, LN_QUAD);
        m_src[c]  = src;
        m_dst[c]  = dst;
        m_mode[c] = mode;
    endtask

    // queues the write that one transfer must make, then steps the model's addresses.
    task automatic model_transfer(input int c);
        int    sz;
        int    am;
        addr_t step;
        sz   = int'(m_mode[c][1:0]);
        am   = int'(m_mode[c][4:2]);
        step = 32'd1 << sz;
        exp_addr_q.push_back(m_dst[c]);
        exp_data_q.push_back((m_src[c] ^ RD_PATTERN) & item_mask(sz));
        exp_size_q.push_back(data_t'(sz));
        case (am)
            0: m_dst[c] = m_dst[c] + step;
            1: m_dst[c] = m_dst[c] - step;
            2: m_src[c] = m_src[c] + step;
            3: m_src[c] = m_src[c] - step;
            default: ;                  // both addresses stay where they are.
        endcase
    endtask

    task automatic wait_reset();
        int n = 0;
        @(negedge clk);
        while (rst && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rst) begin
            errors++;
            $display("timeout at %0t: reset was never released", $time);
        end
    endtask

    // waits until the given number of writes is done and the memory port is idle.
    task automatic wait_writes(input int target);
        int n = 0;
        while ((writes_seen < target || mem_req || mem_ack) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (writes_seen < target || mem_req || mem_ack) begin
            errors++;
            $display("timeout at %0t: %0d of %0d writes seen", $time, writes_seen, target);
        end
        repeat (4) @(negedge clk);      // room for fin and the done pulse.
    endtask

    task automatic no_request(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk);
            checks++;
            assert (!mem_req) else begin
                errors++;
                $display("error at %0t: a dropped trigger started a transfer", $time);
            end
        end
    endtask

    task automatic accept_write();
        if (exp_addr_q.size() == 0) begin
            errors++;
            $display("error at %0t: unexpected write to %h", $time, mem_addr);
        end else begin
            check_eq("mem_addr", mem_addr, exp_addr_q.pop_front());
            check_eq("mem_wdata", mem_wdata, exp_data_q.pop_front());
            check_eq("mem_size", 32'(mem_size), exp_size_q.pop_front());
        end
    endtask

    // four-phase memory responder with a random ack delay for each request.
    always @(posedge clk) begin
        if (rst) begin
            mem_ack  <= 1'b0;
            ack_wait <= 0;
        end else if (!mem_ack && mem_req) begin
            if (ack_wait > 0) begin
                ack_wait <= ack_wait - 1;
            end else begin
                mem_ack   <= 1'b1;
                mem_rdata <= mem_addr ^ RD_PATTERN; // valid for as long as ack stays high.
                if (mem_we) begin
                    accept_write();
                    writes_seen++;
                end
            end
        end else if (mem_ack && !mem_req) begin
            mem_ack  <= 1'b0;
            ack_wait <= $urandom_range(5, 0);
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (dma_done[i])
                    done_cnt[i]++;
            end
        end
    end

    a_req_after_ack: assert property (@(posedge clk) disable iff (rst)
        (mem_ack && !mem_req) |=> !mem_req)
        else begin
            errors++;
            $display("error at %0t: mem_req rose while mem_ack was still high", $time);
        end

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req && !mem_ack) |=>
            (mem_req && $stable(mem_addr) && $stable(mem_we) && $stable(mem_size)
                && $stable(mem_wdata)))
        else begin
            errors++;
            $display("error at %0t: request dropped or changed before mem_ack", $time);
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        (dma_done & $past(dma_done)) == '0)
        else begin
            errors++;
            $display("error at %0t: dma_done stayed high for more than a cycle", $time);
        end

    initial begin
        void'($urandom(32'h9438));
        cen      = 1'b0;
        din      = '0;
        addr     = '0;
        qs       = 1'b0;
        ws       = 1'b0;
        bs       = 1'b0;
        we       = 1'b0;
        nstinc   = 1'b0;
        nstdec   = 1'b0;
        dma_trig = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            done_cnt[c] = 0;
        end
        wait_reset();

        check_eq("mem_req", 32'(mem_req), 32'd0);
        check_eq("dma_done", 32'(dma_done), 32'd0);
        for (int c = 0; c < NUM_CH; c++) begin
            for (int g = 0; g < 3; g++) begin
                reg_read(reg_addr_of(g, c, 0), 32'd0);
            end
        end
        reg_read(reg_addr_of(3, 0, 0), 32'd0);
        report_test(1, "reset values");

        reg_write(reg_addr_of(0, 0, 0), 32'h1122_3344, LN_QUAD);
        reg_read(reg_addr_of(0, 0, 0), 32'h1122_3344);
        reg_write(reg_addr_of(0, 0, 2), 32'h0000_BEEF, LN_WORD); // upper half only.
        reg_read(reg_addr_of(0, 0, 0), 32'hBEEF_3344);
        reg_write(reg_addr_of(0, 0, 1), 32'h0000_005A, LN_BYTE);
        reg_read(reg_addr_of(0, 0, 0), 32'hBEEF_5A44);
        reg_write(reg_addr_of(1, 3, 0), 32'h0102_0304, LN_QUAD);
        reg_write(reg_addr_of(1, 3, 0), 32'h0000_AABB, LN_WORD);
        reg_write(reg_addr_of(1, 3, 3), 32'h0000_00CC, LN_BYTE);
        reg_read(reg_addr_of(1, 3, 0), 32'hCC02_AABB);
        reg_write(reg_addr_of(2, 2, 0), 32'h000A_1234, LN_QUAD); // mode rides over the count.
        reg_read(reg_addr_of(2, 2, 0), 32'h000A_1234);
        reg_read(reg_addr_of(2, 2, 2), 32'h0000_000A);
        reg_write(reg_addr_of(2, 2, 0), 32'h0000_5678, LN_WORD);
        reg_read(reg_addr_of(2, 2, 0), 32'h000A_5678);
        reg_write(reg_addr_of(2, 2, 1), 32'h0000_0077, LN_BYTE);
        reg_read(reg_addr_of(2, 2, 0), 32'h000A_7778);
        reg_write(reg_addr_of(2, 2, 2), 32'h0000_0011, LN_WORD); // addr[1] picks the mode.
        reg_read(reg_addr_of(2, 2, 0), 32'h0011_7778);
        reg_write(reg_addr_of(2, 2, 3), 32'h0000_0005, LN_BYTE);
        reg_read(reg_addr_of(2, 2, 2), 32'h0000_0005);
        report_test(2, "lane writes");

        for (int i = 1; i <= 3; i++) begin
            nest_pulse(1'b1, 1'b0);
            reg_read(reg_addr_of(3, 0, 0), data_t'(i));
        end
        for (int i = 2; i >= 0; i--) begin
            nest_pulse(1'b0, 1'b1);
            reg_read(reg_addr_of(3, 0, 0), data_t'(i));
        end
        report_test(3, "nesting counter");

        configure(1, 32'h0000_4000, 32'h0000_8000, 16'd3, 8'h02); // long, destination up.
        done_base[1] = done_cnt[1];
        for (int k = 0; k < 3; k++) begin
            model_transfer(1);
            trigger(4'b0010);
            wait_writes(writes_seen + 1);
            check_eq("dma_done[1] pulses", 32'(done_cnt[1] - done_base[1]),
                     (k == 2) ? 32'd1 : 32'd0);
        end
        reg_read(reg_addr_of(2, 1, 0), 32'h0002_0000);
        reg_read(reg_addr_of(1, 1, 0), m_dst[1]);
        report_test(4, "single channel");

        configure(0, 32'h0000_1237, 32'h0000_2000, 16'd2, 8'h10); // byte, fixed.
        configure(1, 32'h0000_1302, 32'h0000_2100, 16'd2, 8'h05); // word, destination down.
        configure(2, 32'h0000_1400, 32'h0000_2200, 16'd2, 8'h0A); // long, source up.
        configure(3, 32'h0000_1506, 32'h0000_2300, 16'd2, 8'h0D); // word, source down.
        for (int c = 0; c < NUM_CH; c++) begin
            done_base[c] = done_cnt[c];
        end
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < NUM_CH; c++) begin
                model_transfer(c);      // channel 0 has the highest priority.
            end
            trigger(4'b1111);
            wait_writes(writes_seen + NUM_CH);
            for (int c = 0; c < NUM_CH; c++) begin
                check_eq($sformatf("dma_done[%0d] pulses", c), 32'(done_cnt[c] - done_base[c]),
                         data_t'(r));
            end
        end
        check_eq("writes left in the model", 32'(exp_addr_q.size()), 32'd0);
        report_test(5, "all channels");

        configure(3, 32'h0000_1600, 32'h0000_2400, 16'd0, 8'h02); // count zero.
        trigger(4'b1000);
        no_request(20);
        configure(3, 32'h0000_1600, 32'h0000_2400, 16'd5, 8'h03); // size code 3.
        trigger(4'b1000);
        no_request(20);
        configure(3, 32'h0000_1600, 32'h0000_2400, 16'd5, 8'h14); // addressing code 5.
        trigger(4'b1000);
        no_request(20);
        report_test(6, "dropped triggers");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== flist.f ====
hw/udma_reg_pkg.sv
hw/udma_bus_pkg.sv
hw/udma_chan_if.sv
hw/udma_regs.sv
hw/udma_channel.sv
hw/udma_mover.sv
hw/udma_top.sv
dv/tb_clk.sv
dv/udma_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the DMA testbench with Verilator, runs it and looks for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module udma_tb -Mdir build -o udma_sim -f flist.f

./build/udma_sim | tee sim.log

grep -q "^Test passed$" sim.log
echo "simulation passed"
